//--- gpio_pkg.sv
// Shared widths, encodings and the decode-to-execute request for the AHB GPIO slave.
// Only the low REG_OFS_W address bits are decoded, so the map aliases across the slave window.
// Offsets are byte addresses of 32-bit words; any unaligned offset decodes to REG_NONE.
`default_nettype none

package gpio_pkg;

    // Widths
    localparam int GPIO_W    = 8;                   // Pins on the port
    localparam int DATA_W    = 32;                  // AHB data bus
    localparam int ADDR_W    = 32;                  // AHB address bus
    localparam int REG_OFS_W = 5;                   // Decoded low address bits
    localparam int HSIZE_W   = 3;
    localparam int HBURST_W  = 3;

    // Register offsets inside the slave window
    localparam logic [REG_OFS_W-1:0] OFS_GPO = 5'h00;   // Output data
    localparam logic [REG_OFS_W-1:0] OFS_GPD = 5'h04;   // Direction, 1 drives the pin
    localparam logic [REG_OFS_W-1:0] OFS_GPI = 5'h08;   // Synchronized pin state
    localparam logic [REG_OFS_W-1:0] OFS_SET = 5'h0C;   // Set GPO bits
    localparam logic [REG_OFS_W-1:0] OFS_CLR = 5'h10;   // Clear GPO bits

    // AHB transfer type
    typedef enum logic [1:0] {
        HTRANS_IDLE   = 2'b00,
        HTRANS_BUSY   = 2'b01,
        HTRANS_NONSEQ = 2'b10,
        HTRANS_SEQ    = 2'b11
    } htrans_e;

    // AHB-Lite response, single bit
    typedef enum logic {
        HRESP_OKAY  = 1'b0,
        HRESP_ERROR = 1'b1
    } hresp_e;

    // Register selected by the decoded offset
    typedef enum logic [2:0] {
        REG_GPO  = 3'd0,
        REG_GPD  = 3'd1,
        REG_GPI  = 3'd2,
        REG_SET  = 3'd3,
        REG_CLR  = 3'd4,
        REG_NONE = 3'd5                             // Unmapped or unaligned
    } gpio_reg_e;

    // Request handed from decode to execute and result
    // valid is high for the single data-phase cycle of an accepted transfer
    typedef struct packed {
        logic      valid;
        logic      write;
        gpio_reg_e sel;
    } gpio_req_t;

endpackage : gpio_pkg

`default_nettype wire

//--- ahb_gpio_decode.sv
// AHB-Lite address-phase capture for the GPIO slave.
// Zero wait states: hready stays high and every transfer gets OKAY.
// Upstream HREADY is taken to be this slave's hready, there is no other stall source.
`timescale 1ns/1ns
`default_nettype none

module ahb_gpio_decode (
    input  wire logic                        hclk,
    input  wire logic                        rst_n,
    input  wire logic                        hsel,
    input  wire logic [gpio_pkg::ADDR_W-1:0] haddr,
    input  wire gpio_pkg::htrans_e           htrans,
    input  wire logic                        hwrite,
    output gpio_pkg::gpio_req_t              req,
    output logic                             hready,
    output gpio_pkg::hresp_e                 hresp
);

    import gpio_pkg::*;

    logic      accept;                                  // Address phase taken this cycle
    gpio_reg_e sel_d;

    // Map the low offset bits onto a register, exact match only
    function automatic gpio_reg_e map_offset(input logic [REG_OFS_W-1:0] ofs);
        gpio_reg_e sel;
        case (ofs)
            OFS_GPO: sel = REG_GPO;
            OFS_GPD: sel = REG_GPD;
            OFS_GPI: sel = REG_GPI;
            OFS_SET: sel = REG_SET;
            OFS_CLR: sel = REG_CLR;
            default: sel = REG_NONE;                    // Unaligned or past the map
        endcase
        return sel;
    endfunction

    assign hready = 1'b1;                               // Never stalls
    assign hresp  = HRESP_OKAY;

    // BUSY and IDLE carry no data phase
    assign accept = hsel && hready &&
                    ((htrans == HTRANS_NONSEQ) || (htrans == HTRANS_SEQ));

    assign sel_d = map_offset(haddr[REG_OFS_W-1:0]);

    // Request register, its output marks the data phase
    always_ff @(posedge hclk or negedge rst_n) begin
        if (!rst_n) begin
            req.valid <= 1'b0;
            req.write <= 1'b0;
            req.sel   <= REG_NONE;
        end else begin
            req.valid <= accept;                        // One cycle per accepted transfer
            if (accept) begin
                req.write <= hwrite;
                req.sel   <= sel_d;
            end else begin
                req.write <= 1'b0;
                req.sel   <= REG_NONE;
            end
        end
    end

endmodule : ahb_gpio_decode

`default_nettype wire

//--- gpio_regs.sv
// GPIO execute stage: output and direction registers plus the input synchronizer.
// Writes take the low GPIO_W bits of hwdata, hsize is not honoured.
// Pin reads lag the pads by two hclk cycles through the synchronizer.
`timescale 1ns/1ns
`default_nettype none

module gpio_regs (
    input  wire logic                        hclk,
    input  wire logic                        rst_n,
    input  wire gpio_pkg::gpio_req_t         req,
    input  wire logic [gpio_pkg::DATA_W-1:0] hwdata,
    input  wire logic [gpio_pkg::GPIO_W-1:0] gpi,
    output logic      [gpio_pkg::GPIO_W-1:0] gpo,
    output logic      [gpio_pkg::GPIO_W-1:0] gpd,
    output logic      [gpio_pkg::GPIO_W-1:0] gpi_sync
);

    import gpio_pkg::*;

    logic              wr_en;                           // Write in its data phase
    logic [GPIO_W-1:0] wdata;
    logic [GPIO_W-1:0] gpi_meta;                        // First synchronizer stage

    assign wr_en = req.valid && req.write;
    assign wdata = hwdata[GPIO_W-1:0];                  // Upper bus bits dropped

    // Output data register, also target of set and clear
    always_ff @(posedge hclk or negedge rst_n) begin
        if (!rst_n) begin
            gpo <= '0;
        end else if (wr_en) begin
            case (req.sel)
                REG_GPO: gpo <= wdata;
                REG_SET: gpo <= gpo | wdata;            // Ones set
                REG_CLR: gpo <= gpo & ~wdata;           // Ones clear
                default: gpo <= gpo;
            endcase
        end
    end

    // Direction register, reset leaves every pin an input
    always_ff @(posedge hclk or negedge rst_n) begin
        if (!rst_n) begin
            gpd <= '0;
        end else if (wr_en && (req.sel == REG_GPD)) begin
            gpd <= wdata;
        end
    end

    // Two-flop synchronizer for the asynchronous pads
    // GPI itself is read-only, so bus writes never reach these flops
    always_ff @(posedge hclk or negedge rst_n) begin
        if (!rst_n) begin
            gpi_meta <= '0;
            gpi_sync <= '0;
        end else begin
            gpi_meta <= gpi;
            gpi_sync <= gpi_meta;
        end
    end

endmodule : gpio_regs

`default_nettype wire

//--- gpio_read_mux.sv
// GPIO result stage: read data for the data phase in progress.
// Purely combinational, hrdata is zero outside a valid read.
// Write-only and unmapped offsets read as zero.
`timescale 1ns/1ns
`default_nettype none

module gpio_read_mux (
    input  wire gpio_pkg::gpio_req_t         req,
    input  wire logic [gpio_pkg::GPIO_W-1:0] gpo,
    input  wire logic [gpio_pkg::GPIO_W-1:0] gpd,
    input  wire logic [gpio_pkg::GPIO_W-1:0] gpi_sync,
    output logic      [gpio_pkg::DATA_W-1:0] hrdata
);

    import gpio_pkg::*;

    logic [GPIO_W-1:0] rd_sel;                          // Selected register value
    logic              rd_en;

    assign rd_en = req.valid && !req.write;

    always_comb begin
        case (req.sel)
            REG_GPO: rd_sel = gpo;
            REG_GPD: rd_sel = gpd;
            REG_GPI: rd_sel = gpi_sync;
            default: rd_sel = '0;                       // SET, CLR and NONE
        endcase
    end

    // Zero-extend onto the bus
    assign hrdata = rd_en ? {{(DATA_W-GPIO_W){1'b0}}, rd_sel} : '0;

endmodule : gpio_read_mux

`default_nettype wire

//--- ahb_gpio_top.sv
// AHB-Lite GPIO slave with eight pins, zero wait states and OKAY-only response.
// hsize and hburst are accepted but unused: every write is a full word, bursts act as singles.
// gpd bit high means the pin drives gpo, the pad logic lives outside this block.
`timescale 1ns/1ns
`default_nettype none

module ahb_gpio_top (
    input  wire logic                          hclk,
    input  wire logic                          rst_n,
    // AHB slave port
    input  wire logic                          hsel,
    input  wire logic [gpio_pkg::ADDR_W-1:0]   haddr,
    input  wire gpio_pkg::htrans_e             htrans,
    input  wire logic                          hwrite,
    input  wire logic [gpio_pkg::HSIZE_W-1:0]  hsize,   // Unused, full word only
    input  wire logic [gpio_pkg::HBURST_W-1:0] hburst,  // Unused, no burst behaviour
    input  wire logic [gpio_pkg::DATA_W-1:0]   hwdata,
    output logic      [gpio_pkg::DATA_W-1:0]   hrdata,
    output logic                               hready,
    output gpio_pkg::hresp_e                   hresp,
    // Pins
    input  wire logic [gpio_pkg::GPIO_W-1:0]   gpi,
    output logic      [gpio_pkg::GPIO_W-1:0]   gpo,
    output logic      [gpio_pkg::GPIO_W-1:0]   gpd
);

    import gpio_pkg::*;

    gpio_req_t         req;                             // Data-phase request
    logic [GPIO_W-1:0] gpi_sync;

    ahb_gpio_decode u_decode (
        .hclk   ( hclk   ),
        .rst_n  ( rst_n  ),
        .hsel   ( hsel   ),
        .haddr  ( haddr  ),
        .htrans ( htrans ),
        .hwrite ( hwrite ),
        .req    ( req    ),
        .hready ( hready ),
        .hresp  ( hresp  )
    );

    gpio_regs u_regs (
        .hclk     ( hclk     ),
        .rst_n    ( rst_n    ),
        .req      ( req      ),
        .hwdata   ( hwdata   ),                         // Data phase, straight from the bus
        .gpi      ( gpi      ),
        .gpo      ( gpo      ),
        .gpd      ( gpd      ),
        .gpi_sync ( gpi_sync )
    );

    gpio_read_mux u_read_mux (
        .req      ( req      ),
        .gpo      ( gpo      ),
        .gpd      ( gpd      ),
        .gpi_sync ( gpi_sync ),
        .hrdata   ( hrdata   )
    );

endmodule : ahb_gpio_top

`default_nettype wire

//--- tb_ahb_gpio.sv
// Testbench for the AHB-Lite GPIO slave that needs Verilator timing support.
// A register model follows GPO, GPD and the two-flop pin synchronizer from the register map.
// Inputs change on the falling edge. The model samples on the rising edge and checks run mid-cycle.
`timescale 1ns/1ns
`default_nettype none

module tb_ahb_gpio;

    import gpio_pkg::*;

    localparam logic [ADDR_W-1:0] BASE    = 32'h4000_1000;  // Slave window
    localparam int                TIMEOUT = 50;             // Cycles per bounded wait

    logic                hclk = 1'b0;
    logic                rst_n;
    logic                hsel;
    logic [ADDR_W-1:0]   haddr;
    htrans_e             htrans;
    logic                hwrite;
    logic [HSIZE_W-1:0]  hsize;
    logic [HBURST_W-1:0] hburst;
    logic [DATA_W-1:0]   hwdata;
    logic [GPIO_W-1:0]   gpi;
    logic [DATA_W-1:0]   hrdata;
    logic                hready;
    hresp_e              hresp;
    logic [GPIO_W-1:0]   gpo;
    logic [GPIO_W-1:0]   gpd;

    logic [GPIO_W-1:0]   m_gpo;
    logic [GPIO_W-1:0]   m_gpd;
    logic [GPIO_W-1:0]   pin_hist [2];                      // [1] is the older sample
    logic                dp_valid;                          // Transfer in its data phase
    logic                dp_write;
    logic [4:0]          dp_ofs;
    logic [DATA_W-1:0]   next_wdata;                        // Goes out with the next data phase
    logic [GPIO_W-1:0]   pins;
    int                  issued;
    int                  retired = 0;
    int unsigned         rnd;
    int                  n;

    always #4 hclk = ~hclk;

    ahb_gpio_top uut (
        .hclk   ( hclk   ),
        .rst_n  ( rst_n  ),
        .hsel   ( hsel   ),
        .haddr  ( haddr  ),
        .htrans ( htrans ),
        .hwrite ( hwrite ),
        .hsize  ( hsize  ),
        .hburst ( hburst ),
        .hwdata ( hwdata ),
        .hrdata ( hrdata ),
        .hready ( hready ),
        .hresp  ( hresp  ),
        .gpi    ( gpi    ),
        .gpo    ( gpo    ),
        .gpd    ( gpd    )
    );

    task automatic check_eq(input string name, input logic [DATA_W-1:0] actual,
                            input logic [DATA_W-1:0] expected);
        if (actual !== expected) begin
            $display("ERROR %s: got 0x%08h, expected 0x%08h at %0t",
                     name, actual, expected, $time);
            $display("TESTS FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic timeout_fail(input string what);
        $display("Timeout: %s did not happen within %0d cycles", what, TIMEOUT);
        $display("TESTS FAILED");
        $fatal(1, "timeout waiting for %s", what);
    endtask

    // Expected read word from the register map
    function automatic logic [DATA_W-1:0] model_read(input logic [4:0] ofs);
        logic [DATA_W-1:0] v;
        v = '0;
        case (ofs)
            5'h00:   v[GPIO_W-1:0] = m_gpo;
            5'h04:   v[GPIO_W-1:0] = m_gpd;
            5'h08:   v[GPIO_W-1:0] = pin_hist[1];
            default: v = '0;                                // Write-only or unmapped
        endcase
        return v;
    endfunction

    task automatic model_write(input logic [4:0] ofs, input logic [DATA_W-1:0] data);
        case (ofs)
            5'h00:   m_gpo = data[GPIO_W-1:0];
            5'h04:   m_gpd = data[GPIO_W-1:0];
            5'h0C:   m_gpo = m_gpo | data[GPIO_W-1:0];
            5'h10:   m_gpo = m_gpo & ~data[GPIO_W-1:0];
            default: ;                                      // GPI and unmapped
        endcase
    endtask

    // Model update and capture of the address phase
    always @(posedge hclk or negedge rst_n) begin
        if (!rst_n) begin
            m_gpo       = '0;
            m_gpd       = '0;
            pin_hist[0] = '0;
            pin_hist[1] = '0;
            dp_valid    = 1'b0;
            dp_write    = 1'b0;
            dp_ofs      = '0;
        end else begin
            if (dp_valid && dp_write) begin
                model_write(dp_ofs, hwdata);                // Commits as the data phase ends
            end
            pin_hist[1] = pin_hist[0];
            pin_hist[0] = gpi;
            dp_valid    = hsel && hready &&
                          ((htrans == HTRANS_NONSEQ) || (htrans == HTRANS_SEQ));
            dp_write    = hwrite;
            dp_ofs      = haddr[4:0];
        end
    end

    // Compare in the middle of every cycle
    always @(negedge hclk) begin
        if (rst_n) begin
            check_eq("hrdata", hrdata, (dp_valid && !dp_write) ? model_read(dp_ofs) : '0);
            check_eq("gpo", 32'(gpo), 32'(m_gpo));
            check_eq("gpd", 32'(gpd), 32'(m_gpd));
            check_eq("hready", 32'(hready), 32'd1);
            check_eq("hresp", 32'(hresp), 32'(HRESP_OKAY));
            if (dp_valid) begin
                retired++;
            end
        end
    end

    // One pipelined AHB cycle with a new address phase and the previous write data
    task automatic bus_cycle(input logic sel, input htrans_e trans, input logic write,
                             input logic [4:0] ofs, input logic [DATA_W-1:0] data);
        int k;
        @(negedge hclk);
        hsel       = sel;
        htrans     = trans;
        hwrite     = write;
        haddr      = {BASE[ADDR_W-1:5], ofs};
        hwdata     = next_wdata;
        gpi        = pins;
        next_wdata = data;
        if (sel && ((trans == HTRANS_NONSEQ) || (trans == HTRANS_SEQ))) begin
            issued++;
        end
        k = 0;
        @(posedge hclk);
        while (!hready) begin
            k++;
            if (k > TIMEOUT) timeout_fail("hready");
            @(posedge hclk);
        end
    endtask

    task automatic drain_bus();
        int k;
        k = 0;
        while (retired != issued) begin
            k++;
            if (k > TIMEOUT) timeout_fail("end of the transfer sequence");
            bus_cycle(1'b0, HTRANS_IDLE, 1'b0, 5'h00, '0);
        end
    endtask

    task automatic expect_port(input logic [GPIO_W-1:0] g, input logic [GPIO_W-1:0] d);
        @(negedge hclk);
        check_eq("gpo", 32'(gpo), 32'(g));
        check_eq("gpd", 32'(gpd), 32'(d));
    endtask

    function automatic logic [4:0] pick_offset(input int unsigned r);
        logic [4:0] ofs;
        case (r[2:0])
            3'd0:    ofs = 5'h00;
            3'd1:    ofs = 5'h04;
            3'd2:    ofs = 5'h08;
            3'd3:    ofs = 5'h0C;
            3'd4:    ofs = 5'h10;
            default: ofs = r[12:8];                         // Mostly unmapped offsets
        endcase
        return ofs;
    endfunction

    initial begin
        rst_n = 1'b0;
        repeat (8) @(negedge hclk);
        rst_n = 1'b1;
    end

    initial begin
        hsel       = 1'b0;
        haddr      = BASE;
        htrans     = HTRANS_IDLE;
        hwrite     = 1'b0;
        hsize      = 3'b010;                                // Word
        hburst     = '0;
        hwdata     = '0;
        gpi        = '0;
        next_wdata = '0;
        pins       = '0;
        issued     = 0;
        rnd        = $urandom(71);
        n          = 0;
        while (!rst_n) begin
            n++;
            if (n > TIMEOUT) timeout_fail("reset release");
            @(posedge hclk);
        end

        // Reset values read back as zero
        bus_cycle(1'b1, HTRANS_NONSEQ, 1'b0, 5'h00, '0);
        bus_cycle(1'b1, HTRANS_NONSEQ, 1'b0, 5'h04, '0);
        drain_bus();
        expect_port(8'h00, 8'h00);

        // Plain writes with each read directly behind its write
        bus_cycle(1'b1, HTRANS_NONSEQ, 1'b1, 5'h00, 32'hDEAD_BEA5);
        bus_cycle(1'b1, HTRANS_SEQ,    1'b0, 5'h00, '0);
        bus_cycle(1'b1, HTRANS_NONSEQ, 1'b1, 5'h04, 32'h1234_565A);
        bus_cycle(1'b1, HTRANS_SEQ,    1'b0, 5'h04, '0);
        drain_bus();
        expect_port(8'hA5, 8'h5A);

        // Set and clear
        bus_cycle(1'b1, HTRANS_NONSEQ, 1'b1, 5'h0C, 32'hFFFF_FF0A);
        bus_cycle(1'b1, HTRANS_NONSEQ, 1'b0, 5'h0C, '0);
        bus_cycle(1'b1, HTRANS_NONSEQ, 1'b1, 5'h10, 32'h0000_0021);
        bus_cycle(1'b1, HTRANS_NONSEQ, 1'b0, 5'h10, '0);
        drain_bus();
        expect_port(8'h8E, 8'h5A);

        // Pins through the synchronizer and a write to GPI that must not stick
        pins = 8'h3C;
        repeat (3) bus_cycle(1'b0, HTRANS_IDLE, 1'b0, 5'h00, '0);
        bus_cycle(1'b1, HTRANS_NONSEQ, 1'b0, 5'h08, '0);
        bus_cycle(1'b1, HTRANS_NONSEQ, 1'b1, 5'h08, 32'hFFFF_FFFF);
        bus_cycle(1'b1, HTRANS_NONSEQ, 1'b0, 5'h08, '0);
        drain_bus();
        expect_port(8'h8E, 8'h5A);

        // Transfers that must leave the state alone
        bus_cycle(1'b0, HTRANS_NONSEQ, 1'b1, 5'h00, 32'hFF);
        bus_cycle(1'b1, HTRANS_IDLE,   1'b1, 5'h00, 32'hFF);
        bus_cycle(1'b1, HTRANS_BUSY,   1'b1, 5'h04, 32'hFF);
        bus_cycle(1'b1, HTRANS_NONSEQ, 1'b1, 5'h14, 32'hFF);
        bus_cycle(1'b1, HTRANS_NONSEQ, 1'b1, 5'h1C, 32'hFF);
        bus_cycle(1'b1, HTRANS_NONSEQ, 1'b1, 5'h02, 32'hFF); // Unaligned
        bus_cycle(1'b1, HTRANS_NONSEQ, 1'b0, 5'h14, '0);
        bus_cycle(1'b1, HTRANS_NONSEQ, 1'b0, 5'h02, '0);
        drain_bus();
        expect_port(8'h8E, 8'h5A);

        // Random back-to-back traffic with pins held for 3 cycles
        for (int i = 0; i < 300; i++) begin
            if (i % 3 == 0) begin
                rnd  = $urandom();
                pins = rnd[GPIO_W-1:0];
            end
            rnd = $urandom();
            bus_cycle((rnd[3:0] != 4'h0),
                      (rnd[7:5] == 3'd0) ? htrans_e'({1'b0, rnd[8]}) : htrans_e'({1'b1, rnd[8]}),
                      rnd[10], pick_offset($urandom()), $urandom());
        end
        drain_bus();

        $display("TESTS PASSED");
        $finish;
    end

endmodule : tb_ahb_gpio

`default_nettype wire

//--- vlog.f
gpio_pkg.sv
ahb_gpio_decode.sv
gpio_regs.sv
gpio_read_mux.sv
ahb_gpio_top.sv
tb_ahb_gpio.sv

//--- run.sh
#!/bin/sh
# Builds the GPIO testbench with Verilator and runs it.
# The run passes only if the simulation prints the pass message.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ns \
    --top-module tb_ahb_gpio -f vlog.f -o sim_tb
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

if [ ! -x ./obj_dir/sim_tb ]; then
    echo "Simulation binary not found"
    exit 1
fi

out=$(./obj_dir/sim_tb)
sim_status=$?
echo "$out"

if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$out" | grep -qx "TESTS PASSED"; then
    echo "Simulation passed"
    exit 0
else
    echo "Pass message not found in simulation output"
    exit 1
fi
